/* lsab_fifo.sv */
module lsab_fifo #(
  parameter int  FIFO_DEPTH = 8,
  parameter type entry_t    = logic [31:0]
) (
  input  logic   CLK_n,
  input  logic   RST_MASTER,
  input  logic   i_push,
  input  entry_t i_data,
  input  logic   i_pop,
  output entry_t o_data,
  output logic   o_full,
  output logic   o_empty,
  output logic   o_room
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  entry_t           mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = i_push && !o_full;          // pushes into a full buffer are dropped
  assign do_pop  = i_pop && !o_empty;

  always_ff @(posedge CLK_n)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (!RST_MASTER)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;               // depth is a power of two so it wraps
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign o_data  = mem[rd_ptr];                // head word, valid while not empty
  assign o_full  = (count == CNT_W'(FIFO_DEPTH));
  assign o_empty = (count == '0);
  assign o_room  = (count <= CNT_W'(FIFO_DEPTH - 2)); // two or more free slots

endmodule

/* lsab_in_bank.sv */
module lsab_in_bank #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                             CLK_n,
  input  logic                             RST_MASTER,
  input  logic [snowflake_pkg::NUM_CH-1:0] i_wr_cr,
  input  snowflake_pkg::in_entry_t         i_data_cr [snowflake_pkg::NUM_CH],
  output logic [snowflake_pkg::NUM_CH-1:0] o_full_cr,
  input  snowflake_pkg::section_t          i_section,
  input  logic                             i_pop,
  output snowflake_pkg::in_entry_t         o_head,
  output logic                             o_empty
);

  snowflake_pkg::in_entry_t         head [snowflake_pkg::NUM_CH];
  logic [snowflake_pkg::NUM_CH-1:0] empty;
  logic [snowflake_pkg::NUM_CH-1:0] pop_ch;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one buffer per channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar g = 0; g < snowflake_pkg::NUM_CH; g++)
  begin : g_ch
    assign pop_ch[g] = i_pop && (i_section == snowflake_pkg::section_t'(g));

    lsab_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .entry_t    (snowflake_pkg::in_entry_t)
    ) u_fifo (
      .CLK_n      (CLK_n),
      .RST_MASTER (RST_MASTER),
      .i_push     (i_wr_cr[g]),
      .i_data     (i_data_cr[g]),
      .i_pop      (pop_ch[g]),
      .o_data     (head[g]),
      .o_full     (o_full_cr[g]),
      .o_empty    (empty[g]),
      .o_room     ()                         // the writer outside only looks at full
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side toward the fill mover
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign o_head  = head[i_section];            // head of the section being filled
  assign o_empty = empty[i_section];

endmodule

/* lsab_out_bank.sv */
module lsab_out_bank #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                             CLK_n,
  input  logic                             RST_MASTER,
  input  snowflake_pkg::section_t          i_section,
  input  logic                             i_push,
  input  snowflake_pkg::word_t             i_data,
  output logic                             o_room,
  input  logic [snowflake_pkg::NUM_CH-1:0] i_rd_cw,
  output snowflake_pkg::word_t             o_data_cw [snowflake_pkg::NUM_CH],
  output logic [snowflake_pkg::NUM_CH-1:0] o_empty_cw
);

  logic [snowflake_pkg::NUM_CH-1:0] room;
  logic [snowflake_pkg::NUM_CH-1:0] push_ch;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one buffer per channel
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar g = 0; g < snowflake_pkg::NUM_CH; g++)
  begin : g_ch
    assign push_ch[g] = i_push && (i_section == snowflake_pkg::section_t'(g));

    lsab_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .entry_t    (snowflake_pkg::word_t)
    ) u_fifo (
      .CLK_n      (CLK_n),
      .RST_MASTER (RST_MASTER),
      .i_push     (push_ch[g]),
      .i_data     (i_data),
      .i_pop      (i_rd_cw[g]),
      .o_data     (o_data_cw[g]),
      .o_full     (),                        // the empty mover is throttled by room
      .o_empty    (o_empty_cw[g]),
      .o_room     (room[g])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side from the empty mover
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Room is only reported for the channel the mover is writing to, since
  // the other channels are drained independently by the outside.
  assign o_room = room[i_section];

endmodule

/* mvblck_frdram.sv */
module mvblck_frdram (
  input  logic                        CLK_n,
  input  logic                        RST_MASTER,
  input  snowflake_pkg::blk_cmd_t     i_cmd,
  input  logic                        i_issue,
  output snowflake_pkg::blk_addr_t    o_rd_addr,
  output logic                        o_rd_en,
  input  snowflake_pkg::word_t        i_rd_data,
  output snowflake_pkg::section_t     o_section,
  output logic                        o_push,
  output snowflake_pkg::word_t        o_push_data,
  input  logic                        i_room,
  output snowflake_pkg::blk_status_t  o_status
);

  snowflake_pkg::blk_cmd_t   cmd_q;
  snowflake_pkg::blk_count_t rd_cnt;
  snowflake_pkg::blk_count_t count_sent;
  logic                      working;
  logic                      rd_valid;
  logic                      take;
  logic                      final_push;

  assign take = i_issue && !working && !i_cmd.to_dram;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read-ahead into page memory
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Room means two free slots, so a read issued now and the one still in
  // flight both fit even if the level has not caught up with them yet.
  // With a one-cycle memory no more than these two reads are ever in flight.
  assign o_rd_en = working && i_room && (rd_cnt != cmd_q.count);

  assign final_push = rd_valid && (count_sent + 1'b1 == cmd_q.count);

  always_ff @(posedge CLK_n)
  begin
    if (!RST_MASTER)
    begin
      cmd_q      <= '0;
      working    <= 1'b0;
      rd_cnt     <= '0;
      count_sent <= '0;
      rd_valid   <= 1'b0;
    end
    else
    begin
      rd_valid <= o_rd_en;                           // memory answers one cycle later
      if (take)
      begin
        cmd_q      <= i_cmd;
        working    <= (i_cmd.count != '0);
        rd_cnt     <= '0;
        count_sent <= '0;
      end
      else
      begin
        if (o_rd_en)
        begin
          rd_cnt <= rd_cnt + 1'b1;
        end
        if (rd_valid)
        begin
          count_sent <= count_sent + 1'b1;
        end
        if (final_push)
        begin
          working <= 1'b0;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // returned words go straight out
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign o_rd_addr   = cmd_q.start + snowflake_pkg::blk_addr_t'(rd_cnt);
  assign o_section   = cmd_q.section;
  assign o_push      = rd_valid;
  assign o_push_data = i_rd_data;                    // reads return in issue order

  assign o_status.working    = working;
  assign o_status.count_sent = count_sent;
  assign o_status.last_seen  = 1'b0;                 // output words carry no flag

endmodule

/* mvblck_todram.sv */
module mvblck_todram (
  input  logic                        CLK_n,
  input  logic                        RST_MASTER,
  input  snowflake_pkg::blk_cmd_t     i_cmd,
  input  logic                        i_issue,
  output snowflake_pkg::section_t     o_section,
  output logic                        o_pop,
  input  snowflake_pkg::in_entry_t    i_head,
  input  logic                        i_empty,
  output snowflake_pkg::blk_addr_t    o_wr_addr,
  output snowflake_pkg::word_t        o_wr_data,
  output logic                        o_wr_en,
  output snowflake_pkg::blk_status_t  o_status
);

  snowflake_pkg::blk_cmd_t   cmd_q;
  snowflake_pkg::blk_count_t pop_cnt;
  snowflake_pkg::blk_count_t count_sent;
  snowflake_pkg::in_entry_t  wr_entry;
  logic                      working;
  logic                      last_seen;
  logic                      last_popped;
  logic                      wr_valid;
  logic                      take;
  logic                      final_wr;

  assign take = i_issue && !working && i_cmd.to_dram;  // busy or empty-direction issues drop

  // pop until the count is reached or a flagged word has left the buffer
  assign o_pop = working && !i_empty && !last_popped && (pop_cnt != cmd_q.count);

  assign final_wr = wr_valid && ((count_sent + 1'b1 == cmd_q.count) || wr_entry.last);

  always_ff @(posedge CLK_n)
  begin
    if (!RST_MASTER)
    begin
      cmd_q       <= '0;
      working     <= 1'b0;
      pop_cnt     <= '0;
      count_sent  <= '0;
      last_seen   <= 1'b0;
      last_popped <= 1'b0;
      wr_valid    <= 1'b0;
    end
    else
    begin
      wr_valid <= o_pop;                             // write lands one cycle after the pop
      if (take)
      begin
        cmd_q       <= i_cmd;
        working     <= (i_cmd.count != '0);
        pop_cnt     <= '0;
        count_sent  <= '0;
        last_seen   <= 1'b0;
        last_popped <= 1'b0;
      end
      else
      begin
        if (o_pop)
        begin
          pop_cnt     <= pop_cnt + 1'b1;
          last_popped <= i_head.last;
        end
        if (wr_valid)
        begin
          count_sent <= count_sent + 1'b1;
          last_seen  <= last_seen || wr_entry.last;
        end
        if (final_wr)
        begin
          working <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (o_pop)
    begin
      wr_entry <= i_head;
    end
  end

  assign o_section = cmd_q.section;
  assign o_wr_en   = wr_valid;
  assign o_wr_data = wr_entry.data;
  assign o_wr_addr = cmd_q.start + snowflake_pkg::blk_addr_t'(count_sent);

  assign o_status.working    = working;
  assign o_status.count_sent = count_sent;
  assign o_status.last_seen  = last_seen;

endmodule

/* page_ram.sv */
module page_ram (
  input  logic                     CLK_n,
  input  logic                     i_wr_en,
  input  snowflake_pkg::blk_addr_t i_wr_addr,
  input  snowflake_pkg::word_t     i_wr_data,
  input  logic                     i_rd_en,
  input  snowflake_pkg::blk_addr_t i_rd_addr,
  output snowflake_pkg::word_t     o_rd_data
);

  localparam int NUM_WORDS = 2 ** $bits(snowflake_pkg::blk_addr_t);

  snowflake_pkg::word_t mem [NUM_WORDS];

  always_ff @(posedge CLK_n)
  begin
    if (i_wr_en)
    begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // a read of the address being written returns the old word
  always_ff @(posedge CLK_n)
  begin
    if (i_rd_en)
    begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

/* snowflake_core.f */
snowflake_pkg.sv
lsab_fifo.sv
lsab_in_bank.sv
lsab_out_bank.sv
mvblck_todram.sv
mvblck_frdram.sv
page_ram.sv
snowflake_core.sv
tb_snowflake_core.sv

/* snowflake_core.sv */
module snowflake_core #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                             CLK_n,
  input  logic                             RST_MASTER,
  input  logic [snowflake_pkg::NUM_CH-1:0] i_wr_cr,
  input  snowflake_pkg::in_entry_t         i_data_cr [snowflake_pkg::NUM_CH],
  output logic [snowflake_pkg::NUM_CH-1:0] o_full_cr,
  input  logic [snowflake_pkg::NUM_CH-1:0] i_rd_cw,
  output snowflake_pkg::word_t             o_data_cw [snowflake_pkg::NUM_CH],
  output logic [snowflake_pkg::NUM_CH-1:0] o_empty_cw,
  input  snowflake_pkg::blk_cmd_t          i_cmd,
  input  logic                             i_issue,
  output snowflake_pkg::blk_status_t       o_stat_fill,
  output snowflake_pkg::blk_status_t       o_stat_empty
);

  snowflake_pkg::section_t  fill_section;
  logic                     fill_pop;
  snowflake_pkg::in_entry_t fill_head;
  logic                     fill_empty;
  snowflake_pkg::blk_addr_t wr_addr;
  snowflake_pkg::word_t     wr_data;
  logic                     wr_en;
  snowflake_pkg::blk_addr_t rd_addr;
  logic                     rd_en;
  snowflake_pkg::word_t     rd_data;
  snowflake_pkg::section_t  empty_section;
  logic                     empty_push;
  snowflake_pkg::word_t     push_data;
  logic                     empty_room;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fill path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  lsab_in_bank #(.FIFO_DEPTH(FIFO_DEPTH)) u_lsab_in (
    .CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
    .i_wr_cr(i_wr_cr), .i_data_cr(i_data_cr), .o_full_cr(o_full_cr),
    .i_section(fill_section), .i_pop(fill_pop),
    .o_head(fill_head), .o_empty(fill_empty)
  );

  mvblck_todram u_fill (
    .CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
    .i_cmd(i_cmd), .i_issue(i_issue),                // both movers see every command
    .o_section(fill_section), .o_pop(fill_pop),
    .i_head(fill_head), .i_empty(fill_empty),
    .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_wr_en(wr_en),
    .o_status(o_stat_fill)
  );

  page_ram u_page_ram (
    .CLK_n(CLK_n),
    .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
    .i_rd_en(rd_en), .i_rd_addr(rd_addr), .o_rd_data(rd_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // empty path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  mvblck_frdram u_empty (
    .CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
    .i_cmd(i_cmd), .i_issue(i_issue),
    .o_rd_addr(rd_addr), .o_rd_en(rd_en), .i_rd_data(rd_data),
    .o_section(empty_section), .o_push(empty_push), .o_push_data(push_data),
    .i_room(empty_room),
    .o_status(o_stat_empty)
  );

  lsab_out_bank #(.FIFO_DEPTH(FIFO_DEPTH)) u_lsab_out (
    .CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
    .i_section(empty_section), .i_push(empty_push), .i_data(push_data),
    .o_room(empty_room),
    .i_rd_cw(i_rd_cw), .o_data_cw(o_data_cw), .o_empty_cw(o_empty_cw)
  );

endmodule

/* snowflake_pkg.sv */
package snowflake_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int NUM_CH = 4;                // input and output channels

  typedef logic [31:0] word_t;
  typedef logic [1:0]  section_t;           // channel index
  typedef logic [8:0]  blk_addr_t;          // 512 words of page memory
  typedef logic [5:0]  blk_count_t;         // zero means nothing to move

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one input buffer entry, the flag closes a transfer
  typedef struct packed {
    word_t data;
    logic  last;
  } in_entry_t;

  typedef struct packed {
    blk_addr_t  start;
    blk_count_t count;
    section_t   section;
    logic       to_dram;                    // 1 selects fill, 0 selects empty
  } blk_cmd_t;

  typedef struct packed {
    logic       working;
    blk_count_t count_sent;
    logic       last_seen;                  // fill stopped on a flagged word
  } blk_status_t;

endpackage

/* tb_snowflake_core.sv */
module tb_snowflake_core;

  localparam int FIFO_DEPTH = 8;
  localparam int NUM_ROWS   = 14;
  localparam int TIMEOUT    = 2000;          // cycles allowed for any single wait

  localparam logic [2:0] OP_IDLE       = 3'd0;
  localparam logic [2:0] OP_LOAD       = 3'd1;
  localparam logic [2:0] OP_FILL       = 3'd2;
  localparam logic [2:0] OP_DRAIN      = 3'd3;
  localparam logic [2:0] OP_DRAIN_BUSY = 3'd4;  // drain with a second issue in the middle

  typedef struct packed {
    logic [2:0]                op;
    snowflake_pkg::section_t   section;
    snowflake_pkg::blk_addr_t  start;
    snowflake_pkg::blk_count_t count;        // fill count_sent for an idle row
    int                        last_idx;     // -1 when no word is flagged
    int                        pace;         // cycles per outside access, 0 for a preloaded fill
    snowflake_pkg::blk_count_t exp_sent;     // empty count_sent for an idle row
  } row_t;

  logic                             CLK_n;
  logic                             RST_MASTER;
  logic [snowflake_pkg::NUM_CH-1:0] i_wr_cr;
  snowflake_pkg::in_entry_t         i_data_cr [snowflake_pkg::NUM_CH];
  logic [snowflake_pkg::NUM_CH-1:0] o_full_cr;
  logic [snowflake_pkg::NUM_CH-1:0] i_rd_cw;
  snowflake_pkg::word_t             o_data_cw [snowflake_pkg::NUM_CH];
  logic [snowflake_pkg::NUM_CH-1:0] o_empty_cw;
  snowflake_pkg::blk_cmd_t          i_cmd;
  logic                             i_issue;
  snowflake_pkg::blk_status_t       o_stat_fill;
  snowflake_pkg::blk_status_t       o_stat_empty;

  row_t                     rows [NUM_ROWS];
  snowflake_pkg::word_t     model_mem [512];
  snowflake_pkg::in_entry_t in_model [snowflake_pkg::NUM_CH][64];
  int                       in_rd [snowflake_pkg::NUM_CH];
  int                       in_wr [snowflake_pkg::NUM_CH];
  int                       seed;
  int                       errors;
  bit                       timed_out;

  snowflake_core #(.FIFO_DEPTH(FIFO_DEPTH)) dut (
    .CLK_n(CLK_n), .RST_MASTER(RST_MASTER),
    .i_wr_cr(i_wr_cr), .i_data_cr(i_data_cr), .o_full_cr(o_full_cr),
    .i_rd_cw(i_rd_cw), .o_data_cw(o_data_cw), .o_empty_cw(o_empty_cw),
    .i_cmd(i_cmd), .i_issue(i_issue),
    .o_stat_fill(o_stat_fill), .o_stat_empty(o_stat_empty)
  );

  initial
  begin
    CLK_n = 1'b0;
    forever #50 CLK_n = ~CLK_n;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic next_cycle();
    @(posedge CLK_n);
    #10;                                     // outputs have settled, inputs change here
  endtask

  task automatic check(input bit ok, input string msg);
    assert (ok) else
    begin
      $display("Fail at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
    errors++;
    timed_out = 1'b1;
  endtask

  function automatic row_t make_row(input logic [2:0] op, input int sec, input int start,
                                    input int cnt, input int last_idx, input int pace,
                                    input int exp_sent);
    row_t r;
    r.op       = op;
    r.section  = snowflake_pkg::section_t'(sec);
    r.start    = snowflake_pkg::blk_addr_t'(start);
    r.count    = snowflake_pkg::blk_count_t'(cnt);
    r.last_idx = last_idx;
    r.pace     = pace;
    r.exp_sent = snowflake_pkg::blk_count_t'(exp_sent);
    return r;
  endfunction

  function automatic snowflake_pkg::blk_cmd_t make_cmd(input snowflake_pkg::section_t sec,
      input snowflake_pkg::blk_addr_t start, input snowflake_pkg::blk_count_t cnt,
      input bit to_dram);
    snowflake_pkg::blk_cmd_t c;
    c.start   = start;
    c.count   = cnt;
    c.section = sec;
    c.to_dram = to_dram;
    return c;
  endfunction

  function automatic snowflake_pkg::in_entry_t new_entry(input bit last);
    snowflake_pkg::in_entry_t e;
    e.data = $random(seed);
    e.last = last;
    return e;
  endfunction

  task automatic write_word(input int ch, input snowflake_pkg::in_entry_t e);
    int waited;
    waited = 0;
    while (o_full_cr[ch] && waited < TIMEOUT)
    begin
      next_cycle();
      waited++;
    end
    if (o_full_cr[ch])
    begin
      report_timeout($sformatf("space in input channel %0d", ch));
    end
    else
    begin
      i_wr_cr[ch]             = 1'b1;
      i_data_cr[ch]           = e;
      in_model[ch][in_wr[ch]] = e;
      in_wr[ch]++;
      next_cycle();
      i_wr_cr[ch] = 1'b0;
    end
  endtask

  task automatic issue_cmd(input row_t r, input bit to_dram);
    i_cmd   = make_cmd(r.section, r.start, r.count, to_dram);
    i_issue = 1'b1;
    next_cycle();
    i_issue = 1'b0;
  endtask

  task automatic wait_mover_idle(input bit fill_side);
    int waited;
    waited = 0;
    while ((fill_side ? o_stat_fill.working : o_stat_empty.working) && waited < TIMEOUT)
    begin
      next_cycle();
      waited++;
    end
    if (fill_side ? o_stat_fill.working : o_stat_empty.working)
    begin
      report_timeout(fill_side ? "the fill mover to finish" : "the empty mover to finish");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // row operations
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_idle(input row_t r);
    check(!o_stat_fill.working && !o_stat_empty.working, "a mover is still working");
    check(o_stat_fill.count_sent == r.count,
          $sformatf("fill count_sent is %0d, expected %0d", o_stat_fill.count_sent, r.count));
    check(o_stat_empty.count_sent == r.exp_sent,
          $sformatf("empty count_sent is %0d, expected %0d", o_stat_empty.count_sent,
                    r.exp_sent));
    check(!o_stat_fill.last_seen && !o_stat_empty.last_seen, "last_seen is set");
    check(o_empty_cw == '1, "an output channel is not empty");
    check(o_full_cr == '0, "an input channel reports full");
  endtask

  task automatic load_words(input row_t r);
    for (int i = 0; i < r.count && !timed_out; i++)
    begin
      write_word(r.section, new_entry(i == r.last_idx));
    end
  endtask

  task automatic run_fill(input row_t r);
    snowflake_pkg::in_entry_t e;
    int                       n;
    bit                       last;
    issue_cmd(r, 1'b1);
    check(o_stat_fill.working, "fill mover did not start");
    for (int i = 0; i < r.count && r.pace > 0 && !timed_out; i++)
    begin
      write_word(r.section, new_entry(1'b0));  // trickle in behind the running fill
      repeat (r.pace - 1) next_cycle();
    end
    if (!timed_out)
    begin
      wait_mover_idle(1'b1);
    end
    n    = 0;
    last = 1'b0;
    while (n < r.count && !last && in_rd[r.section] != in_wr[r.section])
    begin
      e = in_model[r.section][in_rd[r.section]];
      in_rd[r.section]++;
      model_mem[r.start + snowflake_pkg::blk_addr_t'(n)] = e.data;
      last = e.last;
      n++;
    end
    check(o_stat_fill.count_sent == r.exp_sent,
          $sformatf("fill count_sent is %0d, expected %0d", o_stat_fill.count_sent, r.exp_sent));
    check(o_stat_fill.last_seen == last,
          $sformatf("fill last_seen is %0d, expected %0d", o_stat_fill.last_seen, last));
  endtask

  task automatic run_drain(input row_t r, input bit busy);
    snowflake_pkg::blk_addr_t addr;
    int                       got;
    int                       gap;
    int                       cycles;
    issue_cmd(r, 1'b0);
    check(o_stat_empty.working, "empty mover did not start");
    got    = 0;
    gap    = 0;
    cycles = 0;
    while (got < r.count && cycles < TIMEOUT)
    begin
      i_rd_cw = '0;
      i_issue = 1'b0;
      if (busy && cycles == 2)
      begin
        check(o_stat_empty.working, "empty mover idle before the second issue");
        i_cmd   = make_cmd(2'd3, 9'd200, 6'd3, 1'b0);  // must be ignored
        i_issue = 1'b1;
      end
      if (!o_stat_empty.working)
      begin
        check(o_stat_empty.count_sent == r.count, "empty mover went idle before its last push");
      end
      if (gap > 0)
      begin
        gap--;
      end
      else if (!o_empty_cw[r.section])
      begin
        addr = r.start + snowflake_pkg::blk_addr_t'(got);
        check(o_data_cw[r.section] == model_mem[addr],
              $sformatf("channel %0d word %0d is %h, expected %h", r.section, got,
                        o_data_cw[r.section], model_mem[addr]));
        i_rd_cw[r.section] = 1'b1;
        got++;
        gap = r.pace - 1;
      end
      next_cycle();
      cycles++;
    end
    i_rd_cw = '0;
    i_issue = 1'b0;
    if (got < r.count)
    begin
      report_timeout($sformatf("word %0d on output channel %0d", got, r.section));
    end
    else
    begin
      wait_mover_idle(1'b0);
      check(o_stat_empty.count_sent == r.exp_sent,
            $sformatf("empty count_sent is %0d, expected %0d", o_stat_empty.count_sent,
                      r.exp_sent));
      repeat (6) next_cycle();               // stray pushes would show up by now
      check(o_empty_cw == '1, "an output channel holds words nobody asked for");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table and main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin
    seed       = 62;
    errors     = 0;
    timed_out  = 1'b0;
    RST_MASTER = 1'b0;
    i_wr_cr    = '0;
    i_rd_cw    = '0;
    i_cmd      = '0;
    i_issue    = 1'b0;
    for (int c = 0; c < snowflake_pkg::NUM_CH; c++)
    begin
      i_data_cr[c] = '0;
      in_rd[c]     = 0;
      in_wr[c]     = 0;
    end
    //                  op             sec start cnt last pace exp
    rows[0]  = make_row(OP_IDLE,       0,  0,    0,  -1,  0,   0);
    rows[1]  = make_row(OP_LOAD,       1,  0,    6,  -1,  0,   0);
    rows[2]  = make_row(OP_FILL,       1,  40,   6,  -1,  0,   6);
    rows[3]  = make_row(OP_DRAIN,      2,  40,   6,  -1,  1,   6);
    rows[4]  = make_row(OP_LOAD,       0,  0,    5,  2,   0,   0);
    rows[5]  = make_row(OP_FILL,       0,  100,  10, -1,  0,   3);
    rows[6]  = make_row(OP_FILL,       0,  103,  2,  -1,  0,   2);
    rows[7]  = make_row(OP_DRAIN,      1,  100,  5,  -1,  1,   5);
    rows[8]  = make_row(OP_FILL,       3,  200,  7,  -1,  3,   7);
    rows[9]  = make_row(OP_DRAIN,      3,  200,  7,  -1,  2,   7);
    rows[10] = make_row(OP_FILL,       2,  300,  20, -1,  1,   20);
    rows[11] = make_row(OP_DRAIN,      0,  300,  20, -1,  4,   20);
    rows[12] = make_row(OP_DRAIN_BUSY, 1,  40,   6,  -1,  2,   6);
    rows[13] = make_row(OP_IDLE,       0,  0,    20, -1,  0,   6);
    repeat (10) @(posedge CLK_n);
    #10;
    RST_MASTER = 1'b1;
    for (int i = 0; i < NUM_ROWS && !timed_out; i++)
    begin
      case (rows[i].op)
        OP_IDLE:  run_idle(rows[i]);
        OP_LOAD:  load_words(rows[i]);
        OP_FILL:  run_fill(rows[i]);
        OP_DRAIN: run_drain(rows[i], 1'b0);
        default:  run_drain(rows[i], 1'b1);
      endcase
      next_cycle();
    end
    $display("errors: %0d", errors);
    if (errors == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
